//--- sim/decode_cases.txt
# word rd rs1 rs2 scalar_imm branch_imm scalar_op vector_op flags cfg_imm vr_addr vw_addr
# flags 11..0: cfg_wen vle32 vse32 vmacc vmv stream_out bne csr lui not_vect scalar_wen stream_valid
123452B7 05 08 03 12345000 492 0 4 00E 48D 80 80  # lui x5 0x12345
FFD10093 01 02 1D FFFFFFFD FF0 1 4 006 FF4 80 80  # addi x1 x2 -3
002081B3 03 01 02 00208000 401 3 4 006 008 00 80  # add x3 x1 x2
C0002203 04 00 00 C0002000 A02 4 4 016 000 00 00  # csr read of cycle into x4
00209463 08 01 02 00209000 004 2 4 024 008 00 00  # bne x1 x2
0002E187 03 05 00 0002E000 401 4 4 400 000 00 80  # vle32 v3 at length code 0
0341F057 00 03 14 0341F000 010 4 4 804 0D0 00 00  # vsetivli to code 3
B66384D7 09 07 06 B6638000 DB4 4 3 101 D98 60 90  # vmacc v9 v7 v6
00056627 0C 0A 00 00056000 006 4 4 200 001 C0 C0  # vse32 v12 (vs2 in rd slot)
004AF057 00 15 04 004AF000 000 4 4 804 012 40 00  # vsetivli to code 5
5E01D5D7 0B 03 00 5E01D000 6F5 4 4 080 780 00 2C  # vmv.v.i v11 3
00D008FF 11 00 0D 00D00000 408 4 4 041 034 34 44  # stream-out v13
030FF157 02 1F 10 030FF000 011 4 4 804 0C3 40 08  # vsetivli to code 7
B7510F57 1E 02 15 B7510000 9BF 4 3 101 DD4 15 1E  # vmacc v30 v2 v21
00026F87 1F 04 00 00026000 40F 4 4 400 000 00 1F  # vle32 v31

//--- src.f
common/isa_pkg.sv
common/vdec_pkg.sv
rtl/instr_fetch.sv
rtl/instr_queue.sv
decoder/vec_isa_decoder.sv
rtl/vec_frontend_top.sv
sim/tb_vec_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_vec_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_vec_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- sim/tb_vec_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vec_frontend;

    localparam int max_cases = 64;
    localparam int n_cols    = 12;

    logic                clk;
    logic                reset;
    vdec_pkg::wb_req_t   wb_req;
    logic [31:0]         wb_dat;
    logic                wb_ack;
    logic                dec_valid;
    vdec_pkg::dec_ctrl_t dec_ctrl;
    logic                dec_ready;

    // columns: word rd rs1 rs2 scalar_imm branch_imm sop vop flags cfg_imm vr vw
    logic [31:0] case_tab [max_cases][n_cols];
    int          n_cases;
    int          rx_count;
    int          errors;
    int          checks;
    logic [31:0] fetch_addr;
    logic [2:0]  exp_vlen;
    logic [15:0] lfsr;
    logic        loaded = 1'b0;

    vec_frontend_top #(
        .queue_depth (4),
        .reset_addr  (32'h0)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .dec_ready (dec_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic next_rand_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] col [n_cols];
        fd = $fopen("sim/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/decode_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < max_cases) begin
                got = $fgets(line, fd);
                // skip blanks and comment lines
                if (got > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                  col[0], col[1], col[2], col[3], col[4], col[5],
                                  col[6], col[7], col[8], col[9], col[10], col[11]);
                    if (got == n_cols) begin
                        for (int k = 0; k < n_cols; k++) begin
                            case_tab[n_cases][k] = col[k];
                        end
                        n_cases++;
                    end else begin
                        errors++;
                        $display("malformed line in the case file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_record(input int i);
        logic [11:0] flags;
        // same bit order as the flags column
        flags = {dec_ctrl.cfg_wen, dec_ctrl.is_vle32, dec_ctrl.is_vse32, dec_ctrl.is_vmacc,
                 dec_ctrl.is_vmv, dec_ctrl.is_stream_out, dec_ctrl.is_bne, dec_ctrl.is_csr,
                 dec_ctrl.is_lui, dec_ctrl.is_not_vect, dec_ctrl.scalar_wen,
                 dec_ctrl.stream_valid};
        check("rd", case_tab[i][1], 32'(dec_ctrl.rd));
        check("rs1", case_tab[i][2], 32'(dec_ctrl.rs1));
        check("rs2", case_tab[i][3], 32'(dec_ctrl.rs2));
        check("scalar_imm", case_tab[i][4], dec_ctrl.scalar_imm);
        check("branch_imm", case_tab[i][5], 32'(dec_ctrl.branch_imm));
        check("scalar_op", case_tab[i][6], 32'(dec_ctrl.scalar_op));
        check("vector_op", case_tab[i][7], 32'(dec_ctrl.vector_op));
        check("class_flags", case_tab[i][8], 32'(flags));
        check("cfg_imm", case_tab[i][9], 32'(dec_ctrl.cfg_imm));
        check("vr_addr", case_tab[i][10], 32'(dec_ctrl.vr_addr));
        check("vw_addr", case_tab[i][11], 32'(dec_ctrl.vw_addr));
        check("vlen", 32'(exp_vlen), 32'(dec_ctrl.vlen));
        // a vsetivli word sets the code for the words after it
        if (case_tab[i][8][11]) begin
            exp_vlen = case_tab[i][0][17:15];
        end
    endtask

    // memory slave and record sink share one lfsr, fixed draw order
    always @(posedge clk) begin : bus_and_sink
        logic rnd;
        int   idx;
        if (reset) begin
            wb_ack    <= 1'b0;
            dec_ready <= 1'b0;
        end else begin
            if (wb_req.stb && !wb_req.cyc) begin
                errors++;
                $display("wishbone stb seen high without cyc at %0t", $time);
            end
            if (wb_ack) begin
                // transfer taken on this edge
                wb_ack <= 1'b0;
            end else if (wb_req.stb) begin
                next_rand_bit(rnd);
                if (rnd) begin
                    check("wb_req.adr", fetch_addr, wb_req.adr);
                    idx = int'(wb_req.adr >> 2);
                    // words past the case list read as zero
                    wb_dat     <= (idx < n_cases) ? case_tab[idx][0] : 32'h0;
                    wb_ack     <= 1'b1;
                    fetch_addr = fetch_addr + 32'd4;
                end
            end
            if (dec_valid && dec_ready) begin
                if (rx_count < n_cases) begin
                    compare_record(rx_count);
                end
                rx_count++;
            end
            next_rand_bit(rnd);
            dec_ready <= rnd;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (40 * n_cases + 8) @(posedge clk);
        $display("run stalled, %0d of %0d records received", rx_count, n_cases);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        reset      = 1'b1;
        wb_ack     = 1'b0;
        wb_dat     = 32'h0;
        dec_ready  = 1'b0;
        lfsr       = 16'd25612;
        fetch_addr = 32'h0;
        exp_vlen   = 3'd0;
        n_cases    = 0;
        rx_count   = 0;
        errors     = 0;
        checks     = 0;
        load_cases();
        if (n_cases == 0) begin
            $display("no decode cases loaded, nothing to run");
            $display("Done: errors found");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (8) @(posedge clk);
            reset <= 1'b0;
            wait (rx_count >= n_cases);
            @(posedge clk);
            $display("records %0d, checks %0d, errors %0d", rx_count, checks, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_frontend_top.sv
`timescale 1ns/100ps
`default_nettype none

module vec_frontend_top #(
    parameter int          queue_depth = 4,
    parameter logic [31:0] reset_addr  = 32'h0
) (
    input  wire logic           clk,
    input  wire logic           reset,
    output vdec_pkg::wb_req_t   wb_req,
    input  wire logic [31:0]    wb_dat,
    input  wire logic           wb_ack,
    output logic                dec_valid,
    output vdec_pkg::dec_ctrl_t dec_ctrl,
    input  wire logic           dec_ready
);

    localparam int cnt_w = $clog2(queue_depth + 1);

    // fetch to queue
    logic             push;
    logic [31:0]      push_data;
    logic [cnt_w-1:0] queue_count;

    // queue to decoder
    logic [31:0]      head;
    logic             not_empty;
    logic             pop;

    instr_fetch #(
        .queue_depth (queue_depth),
        .reset_addr  (reset_addr)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_dat      (wb_dat),
        .wb_ack      (wb_ack),
        .queue_count (queue_count),
        .push        (push),
        .push_data   (push_data)
    );

    instr_queue #(
        .depth     (queue_depth)
    ) u_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .count     (queue_count)
    );

    vec_isa_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .dec_ready (dec_ready)
    );

endmodule

`default_nettype wire

//--- decoder/vec_isa_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module vec_isa_decoder (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic [31:0]  head,
    input  wire logic         not_empty,
    output logic              pop,
    output logic              dec_valid,
    output vdec_pkg::dec_ctrl_t dec_ctrl,
    input  wire logic         dec_ready
);

    localparam int aw = vdec_pkg::rf_addr_w;

    isa_pkg::instr_word_u instr;
    vdec_pkg::dec_ctrl_t  dec_next;
    logic [2:0]           vlen;
    logic                 is_vsetivli;
    logic                 is_addi;
    logic                 is_add;
    logic [4:0]           vs2;
    logic [4:0]           vd;

    // vector register number to base address
    // codes 0..4 keep the low code+1 bits at the top,
    // codes 5..7 slide all five bits further down, both are reg << (aw-1-code)
    function automatic logic [aw-1:0] scale_addr(input logic [4:0] r, input logic [2:0] code);
        logic [aw-1:0] wide;
        wide = {{(aw-5){1'b0}}, r};
        return wide << (aw - 1 - int'(code));
    endfunction

    assign instr = head;

    // take a word when one is there and the output slot frees up
    assign pop = not_empty && (!dec_valid || dec_ready);

    assign is_vsetivli = (instr.s.opcode == isa_pkg::op_vector) &&
                         (instr.s.funct3 == isa_pkg::f3_vsetivli);
    assign is_addi     = (instr.s.opcode == isa_pkg::op_alu_imm) &&
                         (instr.s.funct3 == isa_pkg::f3_add);
    assign is_add      = (instr.s.opcode == isa_pkg::op_alu_reg) &&
                         (instr.s.funct3 == isa_pkg::f3_add) &&
                         (instr.s.funct7 == isa_pkg::f7_base);

    // store names its data register in the rd slot
    assign vd  = instr.s.rd;
    assign vs2 = (instr.s.opcode == isa_pkg::op_vstore) ? instr.s.rd : instr.s.rs2;

    always_comb begin
        dec_next = '0;

        // register fields straight from the word
        dec_next.rs1 = instr.s.rs1;
        dec_next.rs2 = instr.s.rs2;
        dec_next.rd  = instr.s.rd;

        // config layout
        dec_next.cfg_imm = instr.v.cfg_imm;
        dec_next.cfg_wen = is_vsetivli;

        // class flags
        dec_next.is_vle32      = (instr.s.opcode == isa_pkg::op_vload);
        dec_next.is_vse32      = (instr.s.opcode == isa_pkg::op_vstore);
        dec_next.is_vmacc      = (instr.s.opcode == isa_pkg::op_vector) &&
                                 (instr.s.funct3 == isa_pkg::f3_vmacc);
        dec_next.is_vmv        = (instr.s.opcode == isa_pkg::op_vector) &&
                                 (instr.s.funct3 == isa_pkg::f3_vmv_vi);
        dec_next.is_stream_out = (instr.s.opcode == isa_pkg::op_stream_out);
        dec_next.is_bne        = (instr.s.opcode == isa_pkg::op_branch) &&
                                 (instr.s.funct3 == isa_pkg::f3_bne);
        dec_next.is_csr        = (instr.s.opcode == isa_pkg::op_csr) &&
                                 ({instr.s.funct7, instr.s.rs2} == isa_pkg::csr_cycle_addr);
        dec_next.is_lui        = (instr.s.opcode == isa_pkg::op_lui);

        // vsetivli itself counts as non-vector, lets the pipe stall on it
        dec_next.is_not_vect = !(dec_next.is_vmacc || dec_next.is_vle32 ||
                                 dec_next.is_vse32 || dec_next.is_vmv ||
                                 dec_next.is_stream_out);

        // bne offset, b-type bit scramble
        dec_next.branch_imm = {instr.s.funct7[6], instr.s.rd[0],
                               instr.s.funct7[5:0], instr.s.rd[4:1]};

        // sign-extended i-type or upper immediate
        if (is_addi) begin
            dec_next.scalar_imm = {{20{instr.s.funct7[6]}}, instr.s.funct7, instr.s.rs2};
        end else begin
            dec_next.scalar_imm = {instr.s.funct7, instr.s.rs2, instr.s.rs1,
                                   instr.s.funct3, 12'h000};
        end

        // priority as in the scalar unit
        if (dec_next.is_lui) begin
            dec_next.scalar_op = vdec_pkg::sop_lui;
        end else if (is_addi) begin
            dec_next.scalar_op = vdec_pkg::sop_addi;
        end else if (dec_next.is_bne) begin
            dec_next.scalar_op = vdec_pkg::sop_bne;
        end else if (is_add) begin
            dec_next.scalar_op = vdec_pkg::sop_add;
        end else begin
            dec_next.scalar_op = vdec_pkg::sop_none;
        end

        dec_next.vector_op = dec_next.is_vmacc ? vdec_pkg::vop_macc : vdec_pkg::vop_none;
        dec_next.scalar_wen = is_addi || dec_next.is_lui || dec_next.is_csr || is_add;

        // mac result or explicit stream-out feeds the output stream
        dec_next.stream_valid = dec_next.is_vmacc || dec_next.is_stream_out;

        // length in force before this word
        dec_next.vr_addr = scale_addr(vs2, vlen);
        dec_next.vw_addr = scale_addr(vd, vlen);
        dec_next.vlen    = vlen;
    end

    // length register, updated as the vsetivli word leaves the queue
    always_ff @(posedge clk) begin
        if (reset) begin
            vlen <= 3'd0;
        end else if (pop && is_vsetivli) begin
            vlen <= instr.v.vlen;
        end
    end

    // output slot
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (pop) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_ctrl <= dec_next;
        end
    end

    // stalled record must not change under the consumer
    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_ctrl));

endmodule

`default_nettype wire

//--- rtl/instr_queue.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue #(
    parameter int depth = 4
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         push,
    input  wire logic [31:0]                  push_data,
    input  wire logic                         pop,
    output logic [31:0]                       head,
    output logic                              not_empty,
    output logic [$clog2(depth+1)-1:0]        count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [31:0]      mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;

    assign full      = (int'(count) == depth);
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // storage, no reset needed on the data
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // fetch must not overrun us
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

    // decoder only pops a real word
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> not_empty);

endmodule

`default_nettype wire

//--- rtl/instr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instr_fetch #(
    parameter int          queue_depth = 4,
    parameter logic [31:0] reset_addr  = 32'h0
) (
    input  wire logic                               clk,
    input  wire logic                               reset,
    output vdec_pkg::wb_req_t                       wb_req,
    input  wire logic [31:0]                        wb_dat,
    input  wire logic                               wb_ack,
    input  wire logic [$clog2(queue_depth+1)-1:0]   queue_count,
    output logic                                    push,
    output logic [31:0]                             push_data
);

    vdec_pkg::wb_req_t req_q;
    logic              room;
    logic              xfer_done;

    // handshake completes on this edge
    assign xfer_done = req_q.stb && wb_ack;

    // word sitting in push_data is not in the count yet
    assign room = (int'(queue_count) + int'(push)) < queue_depth;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            req_q.adr <= reset_addr;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;
            if (xfer_done) begin
                // close the cycle, one idle cycle follows
                req_q.cyc <= 1'b0;
                req_q.stb <= 1'b0;
                req_q.adr <= req_q.adr + 32'd4;
                push      <= 1'b1;
            end else if (!req_q.stb && room) begin
                req_q.cyc <= 1'b1;
                req_q.stb <= 1'b1;
            end
        end
    end

    // read data latched on the acked edge
    always_ff @(posedge clk) begin
        if (xfer_done) begin
            push_data <= wb_dat;
        end
    end

    assign wb_req = req_q;

    // classic bus: strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc);

endmodule

`default_nettype wire

//--- common/vdec_pkg.sv
`default_nettype none

package vdec_pkg;

    // vector register file address width, sets the record layout
    localparam int rf_addr_w = 8;

    typedef enum logic [2:0] {
        sop_lui  = 3'b000,
        sop_addi = 3'b001,
        sop_bne  = 3'b010,
        sop_add  = 3'b011,
        sop_none = 3'b100
    } scalar_op_e;

    typedef enum logic [2:0] {
        vop_macc = 3'b011,
        vop_none = 3'b100
    } vector_op_e;

    // one decoded instruction
    typedef struct packed {
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [11:0]          cfg_imm;
        logic                 cfg_wen;
        logic                 is_vle32;
        logic                 is_vse32;
        logic                 is_vmacc;
        logic                 is_vmv;
        logic                 is_stream_out;
        logic                 is_bne;
        logic                 is_csr;
        logic                 is_lui;
        logic                 is_not_vect;
        logic [11:0]          branch_imm;
        logic [31:0]          scalar_imm;
        scalar_op_e           scalar_op;
        vector_op_e           vector_op;
        logic                 scalar_wen;
        logic                 stream_valid;
        logic [rf_addr_w-1:0] vr_addr;
        logic [rf_addr_w-1:0] vw_addr;
        logic [2:0]           vlen;
    } dec_ctrl_t;

    // wishbone classic master request, read only
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes, bits 6:0 of the word
    localparam logic [6:0] op_vector     = 7'h57;  // vmacc, vmv.vi, vsetivli
    localparam logic [6:0] op_vload      = 7'h07;  // vle32
    localparam logic [6:0] op_vstore     = 7'h27;  // vse32
    localparam logic [6:0] op_stream_out = 7'h7f;  // custom extension slot
    localparam logic [6:0] op_branch     = 7'h63;
    localparam logic [6:0] op_alu_imm    = 7'h13;
    localparam logic [6:0] op_alu_reg    = 7'h33;
    localparam logic [6:0] op_lui        = 7'h37;
    localparam logic [6:0] op_csr        = 7'h03;  // csr read form used by this core

    // funct3 selectors inside the opcode groups
    localparam logic [2:0] f3_vmacc    = 3'h0;
    localparam logic [2:0] f3_vmv_vi   = 3'h5;
    localparam logic [2:0] f3_vsetivli = 3'h7;
    localparam logic [2:0] f3_bne      = 3'h1;
    localparam logic [2:0] f3_add      = 3'h0;  // shared by add and addi

    // funct7 of plain add
    localparam logic [6:0] f7_base = 7'h00;

    // cycle counter csr, carried in bits 31:20
    localparam logic [11:0] csr_cycle_addr = 12'hc00;

    // r-type style field split
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } scalar_view_t;

    // vsetivli layout
    typedef struct packed {
        logic [1:0]  rsvd;     // bits 31:30, not decoded
        logic [11:0] cfg_imm;  // bits 29:18
        logic [2:0]  vlen;     // bits 17:15, length code
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } vcfg_view_t;

    // one 32-bit word, two readings
    typedef union packed {
        scalar_view_t s;
        vcfg_view_t   v;
    } instr_word_u;

endpackage

`default_nettype wire
